//--- Bender.yml
package:
  name: alu_pipe

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv32i_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/reg_file.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/result_stage.sv
      - hdl/alu_pipe_top.sv
  - target: simulation
    files:
      - verif/alu_pipe_tb.sv

//--- alu_pipe_top.f
+incdir+hdl
hdl/rv32i_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/alu_pipe_top.sv
verif/alu_pipe_tb.sv

//--- hdl/alu_pipe_top.sv
`timescale 1ns/100ps

module alu_pipe_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid_i,
    input  pipe_pkg::instr_in_t instr_i,
    output logic                instr_ready_o,
    output logic                result_valid_o,
    output pipe_pkg::result_t   result_o,
    input  logic                result_ready_i
);

    logic                advance;
    rv32i_pkg::reg_idx_t rs1_idx, rs2_idx;
    rv32i_pkg::word_t    rs1_data, rs2_data;
    pipe_pkg::dec_exe_t  dec_exe;
    logic                res_valid;
    pipe_pkg::result_t   res;
    pipe_pkg::rf_write_t rf_wr;

    assign instr_ready_o = advance;  // single stall condition

    reg_file u_reg_file (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_a_i  (rs1_idx),
        .rd_idx_b_i  (rs2_idx),
        .rd_data_a_o (rs1_data),
        .rd_data_b_o (rs2_data),
        .wr_i        (rf_wr)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst           (rst),
        .advance_i     (advance),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .dec_o         (dec_exe)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst         (rst),
        .advance_i   (advance),
        .dec_i       (dec_exe),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    result_stage u_result (
        .res_valid_i    (res_valid),
        .res_i          (res),
        .result_ready_i (result_ready_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .rf_wr_o        (rf_wr),
        .advance_o      (advance)
    );

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/100ps
`include "rv32i_defs.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance_i,
    input  logic                instr_valid_i,
    input  pipe_pkg::instr_in_t instr_i,
    output rv32i_pkg::reg_idx_t rs1_idx_o,
    output rv32i_pkg::reg_idx_t rs2_idx_o,
    input  rv32i_pkg::word_t    rs1_data_i,
    input  rv32i_pkg::word_t    rs2_data_i,
    output pipe_pkg::dec_exe_t  dec_o
);

    rv32i_pkg::word_t   instr;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv32i_pkg::word_t   imm_i, imm_u, imm_b;
    rv32i_pkg::opcode_e opc;
    pipe_pkg::dec_exe_t dec_d;

    // funct3 to alu op with alt for sub or sra
    function automatic rv32i_pkg::alu_op_e alu_func(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
            3'b001:  return rv32i_pkg::ALU_SLL;
            3'b010:  return rv32i_pkg::ALU_SLT;
            3'b011:  return rv32i_pkg::ALU_SLTU;
            3'b100:  return rv32i_pkg::ALU_XOR;
            3'b101:  return alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
            3'b110:  return rv32i_pkg::ALU_OR;
            default: return rv32i_pkg::ALU_AND;
        endcase
    endfunction

    assign instr     = instr_i.instr;
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign rs1_idx_o = instr[19:15];
    assign rs2_idx_o = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (instr[6:0])
            `RV_OP_OP:     opc = rv32i_pkg::OPC_OP;
            `RV_OP_OP_IMM: opc = rv32i_pkg::OPC_OP_IMM;
            `RV_OP_LUI:    opc = rv32i_pkg::OPC_LUI;
            `RV_OP_AUIPC:  opc = rv32i_pkg::OPC_AUIPC;
            `RV_OP_BRANCH: opc = rv32i_pkg::OPC_BRANCH;
            default:       opc = rv32i_pkg::OPC_ILLEGAL;
        endcase
    end

    always_comb begin
        dec_d       = '0;
        dec_d.valid = 1'b1;
        dec_d.pc    = instr_i.pc;
        dec_d.rd    = instr[11:7];
        dec_d.rs1   = rs1_idx_o;
        dec_d.rs2   = rs2_idx_o;
        dec_d.op_a  = rs1_data_i;
        dec_d.op_b  = rs2_data_i;
        case (opc)
            rv32i_pkg::OPC_OP: begin
                dec_d.alu_op    = alu_func(funct3, funct7[5]);
                dec_d.writes_rd = 1'b1;
                // only add/sub and srl/sra have an alternate form
                dec_d.illegal   = !(funct7 == 7'b0 || (funct7 == 7'b0100000 &&
                                    (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            rv32i_pkg::OPC_OP_IMM: begin
                dec_d.alu_op    = alu_func(funct3, funct3 == 3'b101 && instr[30]);
                dec_d.imm       = imm_i;
                dec_d.b_is_imm  = 1'b1;
                dec_d.writes_rd = 1'b1;
                if (funct3 == 3'b001)
                    dec_d.illegal = funct7 != 7'b0;  // slli
                else if (funct3 == 3'b101)
                    dec_d.illegal = funct7 != 7'b0 && funct7 != 7'b0100000;
            end
            rv32i_pkg::OPC_LUI: begin
                dec_d.alu_op    = rv32i_pkg::ALU_PASS_B;
                dec_d.imm       = imm_u;
                dec_d.b_is_imm  = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            rv32i_pkg::OPC_AUIPC: begin
                dec_d.alu_op    = rv32i_pkg::ALU_ADD;
                dec_d.imm       = imm_u;
                dec_d.a_is_pc   = 1'b1;
                dec_d.b_is_imm  = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            rv32i_pkg::OPC_BRANCH: begin
                dec_d.imm       = imm_b;  // branch offset
                dec_d.is_branch = 1'b1;
                case (funct3)
                    3'b000:  dec_d.br_func = rv32i_pkg::BR_BEQ;
                    3'b001:  dec_d.br_func = rv32i_pkg::BR_BNE;
                    3'b100:  dec_d.br_func = rv32i_pkg::BR_BLT;
                    3'b101:  dec_d.br_func = rv32i_pkg::BR_BGE;
                    3'b110:  dec_d.br_func = rv32i_pkg::BR_BLTU;
                    3'b111:  dec_d.br_func = rv32i_pkg::BR_BGEU;
                    default: dec_d.illegal = 1'b1;
                endcase
            end
            default: dec_d.illegal = 1'b1;
        endcase
        if (dec_d.illegal) begin
            dec_d.writes_rd = 1'b0;  // illegal passes through with no side effects
            dec_d.is_branch = 1'b0;
        end
    end

    // holds while the pipeline is frozen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_o <= '0;
        end else if (advance_i) begin
            if (instr_valid_i)
                dec_o <= dec_d;
            else
                dec_o <= '0;  // bubble
        end
    end

    a_wr_xor_br: assert property (@(posedge clk) disable iff (rst)
        dec_o.valid |-> !(dec_o.writes_rd && dec_o.is_branch));

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/100ps
`include "rv32i_defs.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               advance_i,
    input  pipe_pkg::dec_exe_t dec_i,
    output logic               res_valid_o,
    output pipe_pkg::result_t  res_o
);

    logic                         fwd_a, fwd_b;
    rv32i_pkg::word_t             rs1_val, rs2_val;
    rv32i_pkg::word_t             alu_a, alu_b, alu_y;
    logic [$clog2(`RV_XLEN)-1:0]  shamt;
    logic                         br_cmp;
    pipe_pkg::result_t            res_d;

    // producer one ahead sits in our own result register
    assign fwd_a = res_valid_o && res_o.writes_rd && res_o.rd != '0 && res_o.rd == dec_i.rs1;
    assign fwd_b = res_valid_o && res_o.writes_rd && res_o.rd != '0 && res_o.rd == dec_i.rs2;

    assign rs1_val = fwd_a ? res_o.value : dec_i.op_a;
    assign rs2_val = fwd_b ? res_o.value : dec_i.op_b;

    assign alu_a = dec_i.a_is_pc  ? dec_i.pc  : rs1_val;
    assign alu_b = dec_i.b_is_imm ? dec_i.imm : rs2_val;
    assign shamt = alu_b[$clog2(`RV_XLEN)-1:0];

    always_comb begin
        case (dec_i.alu_op)
            rv32i_pkg::ALU_ADD:  alu_y = alu_a + alu_b;
            rv32i_pkg::ALU_SUB:  alu_y = alu_a - alu_b;
            rv32i_pkg::ALU_SLL:  alu_y = alu_a << shamt;
            rv32i_pkg::ALU_SLT:  alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv32i_pkg::ALU_SLTU: alu_y = {31'b0, alu_a < alu_b};
            rv32i_pkg::ALU_XOR:  alu_y = alu_a ^ alu_b;
            rv32i_pkg::ALU_SRL:  alu_y = alu_a >> shamt;
            rv32i_pkg::ALU_SRA:  alu_y = $signed(alu_a) >>> shamt;
            rv32i_pkg::ALU_OR:   alu_y = alu_a | alu_b;
            rv32i_pkg::ALU_AND:  alu_y = alu_a & alu_b;
            default:             alu_y = alu_b;  // pass b
        endcase
    end

    // branch compare always on register operands
    always_comb begin
        case (dec_i.br_func)
            rv32i_pkg::BR_BEQ:  br_cmp = rs1_val == rs2_val;
            rv32i_pkg::BR_BNE:  br_cmp = rs1_val != rs2_val;
            rv32i_pkg::BR_BLT:  br_cmp = $signed(rs1_val) < $signed(rs2_val);
            rv32i_pkg::BR_BGE:  br_cmp = $signed(rs1_val) >= $signed(rs2_val);
            rv32i_pkg::BR_BLTU: br_cmp = rs1_val < rs2_val;
            default:            br_cmp = rs1_val >= rs2_val;
        endcase
    end

    always_comb begin
        res_d.pc        = dec_i.pc;
        res_d.rd        = dec_i.rd;
        res_d.value     = dec_i.writes_rd ? alu_y : '0;  // zero when nothing is written
        res_d.writes_rd = dec_i.writes_rd;
        res_d.br_en     = dec_i.is_branch && br_cmp;
        res_d.illegal   = dec_i.illegal;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid_o <= 1'b0;
            res_o       <= '0;
        end else if (advance_i) begin
            res_valid_o <= dec_i.valid;
            if (dec_i.valid)
                res_o <= res_d;
            else
                res_o <= '0;
        end
    end

    // stalled result must not move under the consumer
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        res_valid_o && !advance_i |=> $stable(res_o) && res_valid_o);

endmodule

//--- hdl/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        rv32i_pkg::word_t instr;
        rv32i_pkg::word_t pc;
    } instr_in_t;

    // decode to execute
    typedef struct packed {
        logic                valid;
        rv32i_pkg::word_t    pc;
        rv32i_pkg::reg_idx_t rd;
        rv32i_pkg::reg_idx_t rs1;
        rv32i_pkg::reg_idx_t rs2;
        rv32i_pkg::word_t    op_a;      // rs1 value at decode
        rv32i_pkg::word_t    op_b;      // rs2 value at decode
        rv32i_pkg::word_t    imm;
        rv32i_pkg::alu_op_e  alu_op;
        rv32i_pkg::br_func_e br_func;
        logic                a_is_pc;
        logic                b_is_imm;
        logic                is_branch;
        logic                writes_rd;
        logic                illegal;
    } dec_exe_t;

    // execute to result, also the output payload
    typedef struct packed {
        rv32i_pkg::word_t    pc;
        rv32i_pkg::reg_idx_t rd;
        rv32i_pkg::word_t    value;
        logic                writes_rd;
        logic                br_en;
        logic                illegal;
    } result_t;

    typedef struct packed {
        logic                en;
        rv32i_pkg::reg_idx_t idx;
        rv32i_pkg::word_t    value;
    } rf_write_t;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/100ps
`include "rv32i_defs.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  rv32i_pkg::reg_idx_t rd_idx_a_i,
    input  rv32i_pkg::reg_idx_t rd_idx_b_i,
    output rv32i_pkg::word_t    rd_data_a_o,
    output rv32i_pkg::word_t    rd_data_b_o,
    input  pipe_pkg::rf_write_t wr_i
);

    rv32i_pkg::word_t regs [1:`RV_NUM_REGS-1];  // no storage for x0

    // x0 reads zero, same-cycle write bypasses the array
    function automatic rv32i_pkg::word_t read_port(input rv32i_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wr_i.en && wr_i.idx == idx)
            return wr_i.value;
        return regs[idx];
    endfunction

    // architectural state starts at zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_i.en && wr_i.idx != '0) begin
            regs[wr_i.idx] <= wr_i.value;
        end
    end

    assign rd_data_a_o = read_port(rd_idx_a_i);
    assign rd_data_b_o = read_port(rd_idx_b_i);

    // result stage filters rd == 0 before asking
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wr_i.en |-> wr_i.idx != '0);

endmodule

//--- hdl/result_stage.sv
`timescale 1ns/100ps

module result_stage (
    input  logic                res_valid_i,
    input  pipe_pkg::result_t   res_i,
    input  logic                result_ready_i,
    output logic                result_valid_o,
    output pipe_pkg::result_t   result_o,
    output pipe_pkg::rf_write_t rf_wr_o,
    output logic                advance_o
);

    logic taken;  // result handshake this cycle

    assign result_valid_o = res_valid_i;
    assign result_o       = res_i;

    assign taken = res_valid_i && result_ready_i;

    // empty slot or leaving slot lets every stage move
    assign advance_o = !res_valid_i || result_ready_i;

    // commit only on handshake, never to x0
    assign rf_wr_o.en    = taken && res_i.writes_rd && res_i.rd != '0;
    assign rf_wr_o.idx   = res_i.rd;
    assign rf_wr_o.value = res_i.value;

endmodule

//--- hdl/rv32i_defs.svh
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// architectural widths
`define RV_XLEN     32
`define RV_NUM_REGS 32

// major opcodes, instr[6:0]
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_BRANCH 7'b1100011

// marks anything outside the supported set
`define RV_OP_NONE   7'b0000000

`endif

//--- hdl/rv32i_pkg.sv
`include "rv32i_defs.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    // values follow the instruction encoding
    typedef enum logic [6:0] {
        OPC_OP      = `RV_OP_OP,
        OPC_OP_IMM  = `RV_OP_OP_IMM,
        OPC_LUI     = `RV_OP_LUI,
        OPC_AUIPC   = `RV_OP_AUIPC,
        OPC_BRANCH  = `RV_OP_BRANCH,
        OPC_ILLEGAL = `RV_OP_NONE
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    // funct3 encodings of the branch group
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_func_e;

endpackage

//--- verif/alu_pipe_tb.sv
`timescale 1ns/100ps

module alu_pipe_tb;

    localparam int NUM_VECS  = 26;
    localparam int NUM_TOTAL = 2 * NUM_VECS;          // random pass, then steady pass
    localparam int WATCHDOG  = NUM_TOTAL * 20 + 200;  // in cycles

    logic                clk;
    logic                rst;
    logic                instr_valid_i;
    pipe_pkg::instr_in_t instr_i;
    logic                instr_ready_o;
    logic                result_valid_o;
    pipe_pkg::result_t   result_o;
    logic                result_ready_i;

    logic [31:0]       vec_mem [0:4*NUM_VECS-1];  // four words per entry
    int                accept_cycle [0:NUM_TOTAL-1];
    int                cycle = 0;
    int                exp_idx = 0;
    int                errors = 0;
    logic              steady;
    logic              held = 1'b0;
    pipe_pkg::result_t held_res = '0;

    alu_pipe_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_ready_i (result_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_mismatch(input string field, input int idx,
                                   input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("Mismatch at %0t: result %0d %s is %h, expected %h",
                 $time, idx, field, got, exp);
    endtask

    // entry index wraps once per pass
    task automatic check_result(input int idx);
        int          base;
        logic [31:0] flags;
        base  = 4 * (idx % NUM_VECS);
        flags = vec_mem[base+3];
        if (result_o.pc !== vec_mem[base+1])
            report_mismatch("pc", idx, result_o.pc, vec_mem[base+1]);
        if (result_o.rd !== flags[20:16])
            report_mismatch("rd", idx, result_o.rd, flags[20:16]);
        if (result_o.value !== vec_mem[base+2])
            report_mismatch("value", idx, result_o.value, vec_mem[base+2]);
        if (result_o.writes_rd !== flags[8])
            report_mismatch("writes_rd", idx, result_o.writes_rd, flags[8]);
        if (result_o.br_en !== flags[4])
            report_mismatch("br_en", idx, result_o.br_en, flags[4]);
        if (result_o.illegal !== flags[0])
            report_mismatch("illegal", idx, result_o.illegal, flags[0]);
        if (idx >= NUM_VECS && cycle - accept_cycle[idx] != 2)  // no stalls in steady pass
            report_mismatch("latency", idx, cycle - accept_cycle[idx], 2);
    endtask

    task automatic drive_pass(input int first);
        int idles;
        for (int i = 0; i < NUM_VECS; i++) begin
            idles = 0;
            if (!steady && $urandom % 4 == 0)
                idles = $urandom % 3 + 1;
            if (idles > 0) begin
                instr_valid_i <= 1'b0;
                repeat (idles) @(posedge clk);
            end
            instr_valid_i  <= 1'b1;
            instr_i.instr  <= vec_mem[4*i];
            instr_i.pc     <= vec_mem[4*i+1];
            @(posedge clk);
            while (!instr_ready_o)
                @(posedge clk);
            accept_cycle[first+i] = cycle;
        end
        instr_valid_i <= 1'b0;
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            if (steady)
                result_ready_i <= 1'b1;
            else
                result_ready_i <= ($urandom % 4) != 0;  // roughly one stall in four
        end
    endtask

    // checks every taken result and the freeze under stall
    initial begin
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (held && (!result_valid_o || result_o !== held_res)) begin
                    errors++;
                    $display("Mismatch at %0t: result_o moved while stalled", $time);
                end
                if (result_valid_o && !result_ready_i && instr_ready_o) begin
                    errors++;
                    $display("Mismatch at %0t: instr_ready_o high under back-pressure", $time);
                end
                if (result_valid_o && result_ready_i) begin
                    if (exp_idx >= NUM_TOTAL) begin
                        errors++;
                        $display("An extra result arrived at %0t after all were taken", $time);
                    end else begin
                        check_result(exp_idx);
                    end
                    exp_idx++;
                end
                held     = result_valid_o && !result_ready_i;
                held_res = result_o;
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Run hung: %0d of %0d results after %0d cycles", exp_idx, NUM_TOTAL, WATCHDOG);
        $display("Results checked: %0d, errors: %0d", exp_idx, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h511f));
        rst            = 1'b1;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        result_ready_i = 1'b0;
        steady         = 1'b0;
        $readmemh("verif/alu_pipe_vectors.txt", vec_mem);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (result_valid_o !== 1'b0 || instr_ready_o !== 1'b1) begin
            errors++;
            $display("Mismatch at %0t: after reset result_valid_o %b instr_ready_o %b",
                     $time, result_valid_o, instr_ready_o);
        end
        fork
            drive_ready();
        join_none
        drive_pass(0);
        wait (exp_idx == NUM_VECS);
        @(posedge clk);
        steady <= 1'b1;
        repeat (2) @(posedge clk);  // ready settles high first
        drive_pass(NUM_VECS);
        wait (exp_idx == NUM_TOTAL);
        repeat (4) @(posedge clk);
        $display("Results checked: %0d, errors: %0d", exp_idx, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- verif/alu_pipe_vectors.txt
// columns: instruction word, pc, expected value, expected flags
// flags as 00RR0WBI: RR = rd, W = writes_rd, B = br_en, I = illegal
FFB00093 00001000 FFFFFFFB 00010100
00700113 00001004 00000007 00020100
002081B3 00001008 00000002 00030100
40110233 0000100C 0000000C 00040100
0020A2B3 00001010 00000001 00050100
0020B333 00001014 00000000 00060100
4020D3B3 00001018 FFFFFFFF 00070100
4010D413 0000101C FFFFFFFD 00080100
01C0D493 00001020 0000000F 00090100
00411513 00001024 00000070 000A0100
FFF0C593 00001028 00000004 000B0100
00256633 0000102C 00000077 000C0100
001676B3 00001030 00000073 000D0100
12345737 00001034 12345000 000E0100
00001797 00001038 00002038 000F0100
00170013 0000103C 12345001 00000100
00000833 00001040 00000000 00100100
02108063 00001044 00000000 00000010
02209063 00001048 00000000 00000010
02114063 0000104C 00000000 00000000
02115063 00001050 00000000 00000010
02116063 00001054 00000000 00000010
02117063 00001058 00000000 00000000
0000A283 0000105C 00000000 00050001
00E788B3 00001060 12347038 00110100
00028933 00001064 00000001 00120100
